//--- bench/sdram_model.sv
`timescale 1ns/1ps

module sdram_model #(
    parameter int power_cycles     = 200,   // controller power-up wait
    parameter int refresh_interval = 300,
    parameter int trcd             = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::sdram_cmd_t cmd,
    input  logic [1:0]            ba,
    input  logic [12:0]           a,
    input  logic [1:0]            dqm,
    input  logic [15:0]           dq_out,
    input  logic                  dq_oe,
    output logic [15:0]           dq_in
);
    localparam int cl        = sdram_pkg::mode_cas_latency;
    localparam int ref_limit = refresh_interval + 40;   // scheduler slack

    logic [15:0] mem [0:32767];     // {row[4:0], bank, col}
    logic [15:0] rd_pipe [0:cl-1];  // cas latency delay line
    logic [15:0] rd_word;
    logic        bank_open [0:3];
    logic [12:0] open_row [0:3];
    int          act_cyc [0:3];
    int          cyc;
    int          init_step;         // 0 pre, 1..2 refresh, 3 mode, 4 running
    int          busy_cyc;          // earliest cycle for the next command
    int          ref_cyc;           // last refresh seen
    logic        starved;
    logic [14:0] idx;
    int          errors;

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic rule_error(input string what);
        errors++;
        $display("sdram model error at %0t: %s", $time, what);
    endtask

    initial begin
        errors = 0;
        for (int i = 0; i < 32768; i++)
            mem[i] = 16'(i) ^ 16'hc35a;   // address dependent fill
        for (int k = 0; k < cl; k++)
            rd_pipe[k] = 16'h0;
    end

    always @(posedge clk) begin
        rd_word = 16'h0;
        if (rst) begin
            cyc       = 0;
            init_step = 0;
            busy_cyc  = 0;
            ref_cyc   = 0;
            starved   = 1'b0;
            for (int b = 0; b < 4; b++)
                bank_open[b] = 1'b0;
        end else begin
            cyc++;
            if (cmd != sdram_pkg::cmd_nop && cmd != sdram_pkg::cmd_deselect)
                assert (cyc >= busy_cyc) else rule_error("command inside a recovery time");
            assert (!dq_oe || cmd == sdram_pkg::cmd_write) else rule_error("dq driven outside a WRITE");
            case (cmd)
                sdram_pkg::cmd_precharge: begin
                    assert (init_step == 0) else rule_error("PRECHARGE out of the init order");
                    assert (a[10]) else rule_error("initial PRECHARGE does not cover all banks");
                    assert (cyc > power_cycles) else rule_error("PRECHARGE before the power-up wait");
                    init_step = 1;
                    busy_cyc  = cyc + sdram_pkg::trp;
                end
                sdram_pkg::cmd_refresh: begin
                    if (init_step == 1 || init_step == 2)
                        init_step++;   // the two init refreshes
                    else
                        assert (init_step == 4) else rule_error("REFRESH out of the init order");
                    for (int b = 0; b < 4; b++)
                        assert (!bank_open[b]) else rule_error("REFRESH with a bank open");
                    busy_cyc = cyc + sdram_pkg::trfc;
                    ref_cyc  = cyc;
                end
                sdram_pkg::cmd_load_mode: begin
                    assert (init_step == 3) else rule_error("LOAD_MODE out of the init order");
                    assert (a == sdram_pkg::mode_word)
                        else value_error("sdram_a mode", 32'(a), 32'(sdram_pkg::mode_word));
                    init_step = 4;
                    busy_cyc  = cyc + sdram_pkg::tmrd;
                end
                sdram_pkg::cmd_active: begin
                    assert (init_step == 4) else rule_error("ACTIVE before LOAD_MODE");
                    assert (!bank_open[ba]) else rule_error("ACTIVE to a bank already open");
                    assert (a[12:5] == '0) else value_error("sdram_a row", 32'(a), 32'(a[4:0]));
                    bank_open[ba] = 1'b1;
                    open_row[ba]  = a;
                    act_cyc[ba]   = cyc;
                end
                sdram_pkg::cmd_read, sdram_pkg::cmd_write: begin
                    assert (bank_open[ba]) else rule_error("access to a bank with no open row");
                    assert (cyc - act_cyc[ba] >= trcd) else rule_error("access sooner than trcd");
                    assert (a[10]) else rule_error("access without auto-precharge");
                    idx = {open_row[ba][4:0], ba, a[7:0]};
                    if (cmd == sdram_pkg::cmd_write) begin
                        assert (dq_oe) else rule_error("WRITE without dq driven");
                        if (!dqm[0])
                            mem[idx][7:0] = dq_out[7:0];
                        if (!dqm[1])
                            mem[idx][15:8] = dq_out[15:8];
                    end else begin
                        rd_word = mem[idx];
                    end
                    bank_open[ba] = 1'b0;   // auto precharge closes the row
                end
                default: ;   // nop, deselect
            endcase
            if (init_step == 4 && !starved)
                assert (cyc - ref_cyc <= ref_limit) else begin
                    starved = 1'b1;   // report once
                    rule_error("no REFRESH within the refresh limit");
                end
        end
        rd_pipe[0] <= rd_word;
        for (int k = 1; k < cl; k++)
            rd_pipe[k] <= rd_pipe[k-1];
    end

    assign dq_in = rd_pipe[cl-1];   // valid cl edges after READ

endmodule

//--- bench/tb_spirw_sdram.sv
`timescale 1ns/1ps

module tb_spirw_sdram;
    localparam int init_cycles      = 200;
    localparam int refresh_interval = 300;
    localparam int trcd             = 2;
    localparam int half_period      = 16;   // sclk half period in clocks
    localparam int byte_gap         = 64;   // idle clocks after each byte
    localparam int byte_cycles      = 16 * half_period + byte_gap;
    // 12 transactions of up to 20 bytes plus init, with margin
    localparam int max_cycles       = (init_cycles + 12 * 20 * byte_cycles) * 5 / 2;

    logic                  clk;
    logic                  rst;
    logic                  csn;
    logic                  sclk;
    logic                  mosi;
    logic                  miso;
    sdram_pkg::sdram_cmd_t sdram_cmd;
    logic [1:0]            sdram_ba;
    logic [12:0]           sdram_a;
    logic [1:0]            sdram_dqm;
    logic [15:0]           sdram_dq_out;
    logic                  sdram_dq_oe;
    logic [15:0]           sdram_dq_in;
    logic                  ready;

    int         errors = 0;
    int         cycle = 0;
    integer     seed;
    logic [7:0] sb_data [0:65535];   // expected memory bytes
    logic [7:0] burst [0:31];        // write payload

    spirw_sdram_top #(
        .init_cycles      (init_cycles),
        .refresh_interval (refresh_interval),
        .trcd             (trcd)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .csn          (csn),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso         (miso),
        .sdram_cmd    (sdram_cmd),
        .sdram_ba     (sdram_ba),
        .sdram_a      (sdram_a),
        .sdram_dqm    (sdram_dqm),
        .sdram_dq_out (sdram_dq_out),
        .sdram_dq_oe  (sdram_dq_oe),
        .sdram_dq_in  (sdram_dq_in),
        .ready        (ready)
    );

    sdram_model #(
        .power_cycles     (init_cycles),
        .refresh_interval (refresh_interval),
        .trcd             (trcd)
    ) mem0 (
        .clk    (clk),
        .rst    (rst),
        .cmd    (sdram_cmd),
        .ba     (sdram_ba),
        .a      (sdram_a),
        .dqm    (sdram_dqm),
        .dq_out (sdram_dq_out),
        .dq_oe  (sdram_dq_oe),
        .dq_in  (sdram_dq_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle);
            $display("errors: bench %0d, sdram model %0d", errors, mem0.errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // reset values, sampled mid cycle
    always @(negedge clk) begin
        if (cycle >= 1 && cycle <= 12) begin
            assert (sdram_cmd == sdram_pkg::cmd_nop)
                else log_mismatch("sdram_cmd", 32'(sdram_cmd), 32'(sdram_pkg::cmd_nop));
            assert (!sdram_dq_oe) else log_mismatch("sdram_dq_oe", 32'(sdram_dq_oe), 32'h0);
            assert (!ready) else log_mismatch("ready", 32'(ready), 32'h0);
            assert (!miso) else log_mismatch("miso", 32'(miso), 32'h0);
        end
    end

    // spi mode 0, msb first
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            mosi <= tx[i];   // changes while sclk low
            repeat (half_period) @(posedge clk);
            @(negedge clk);
            rx[i] = miso;
            @(posedge clk);
            sclk <= 1'b1;
            repeat (half_period) @(posedge clk);
            sclk <= 1'b0;
        end
        repeat (byte_gap) @(posedge clk);   // room for the sdram access
    endtask

    task automatic open_frame(input logic [7:0] op, input logic [15:0] addr);
        logic [7:0] dummy;
        csn <= 1'b0;
        repeat (half_period) @(posedge clk);
        shift_byte(op, dummy);
        shift_byte(addr[15:8], dummy);   // high byte first
        shift_byte(addr[7:0], dummy);
    endtask

    task automatic close_frame;
        csn <= 1'b1;
        repeat (2 * byte_gap) @(posedge clk);
    endtask

    task automatic fill_burst(input int len);
        for (int k = 0; k < len; k++)
            burst[k] = 8'($random(seed));
    endtask

    task automatic spi_write(input logic [15:0] addr, input int len);
        logic [7:0] dummy;
        open_frame(8'(spi_pkg::op_write), addr);
        for (int k = 0; k < len; k++) begin
            shift_byte(burst[k], dummy);
            sb_data[16'(addr + k)] = burst[k];
        end
        close_frame();
    endtask

    task automatic spi_read(input logic [15:0] addr, input int len);
        logic [7:0]  got;
        logic [15:0] at;
        open_frame(8'(spi_pkg::op_read), addr);
        for (int k = 0; k < len; k++) begin
            shift_byte(8'h00, got);
            at = 16'(addr + k);   // address steps once per data byte
            assert (got == sb_data[at]) else log_mismatch("miso byte", 32'(got), 32'(sb_data[at]));
        end
        close_frame();
    endtask

    initial begin
        logic [15:0] base;
        int          wait_n;
        seed = 12;
        rst  = 1'b1;
        csn  = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        wait_n = 0;
        while (!ready && wait_n < init_cycles + 100) begin
            @(posedge clk);
            wait_n++;
        end
        assert (ready) else note_failure("ready did not rise after initialisation");

        // first two runs cross into the next bank and the next row
        for (int t = 0; t < 4; t++) begin
            case (t)
                0:       base = 16'h01f8;
                1:       base = 16'h07f8;
                default: base = 16'($random(seed));
            endcase
            fill_burst(16);
            spi_write(base, 16);
            spi_read(base, 16);
        end

        // low and high lane of one word in separate writes
        base = 16'($random(seed)) & 16'hfffe;
        fill_burst(1);
        spi_write(base, 1);
        fill_burst(1);
        spi_write(16'(base + 1), 1);
        spi_read(base, 2);

        repeat (3 * refresh_interval) @(posedge clk);   // idle refreshes
        $display("errors: bench %0d, sdram model %0d", errors, mem0.errors);
        if (errors + mem0.errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
source/spi_pkg.sv
source/sdram_pkg.sv
source/spirw_slave.sv
source/sdram_ctrl.sv
source/spirw_sdram_top.sv
bench/sdram_model.sv
bench/tb_spirw_sdram.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_spirw_sdram -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1

//--- source/sdram_ctrl.sv
`timescale 1ns/1ps

module sdram_ctrl #(
    parameter int init_cycles      = 20000,   // power-up wait
    parameter int refresh_interval = 750,     // cycles between refreshes
    parameter int trcd             = 2        // active to read/write
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd,
    input  logic                   wr,
    input  spi_pkg::mem_req_t      req,
    output logic                   ack,
    output logic [7:0]             rdata,
    output logic                   ready,
    output sdram_pkg::sdram_pins_t pins,
    input  logic [15:0]            dq_in
);
    localparam int cnt_w = $clog2(init_cycles + 1);
    localparam int ref_w = $clog2(refresh_interval + 1);

    sdram_pkg::ctrl_state_t state;
    logic [cnt_w-1:0]       wait_cnt;     // shared delay counter
    logic                   wait_done;
    logic [ref_w-1:0]       ref_cnt;
    logic                   ref_pending;
    logic                   ref_take;
    logic                   second_ref;   // init refresh count
    logic                   lane;         // byte lane from addr bit 0
    logic [7:0]             col;
    logic [1:0]             bank;
    logic [4:0]             row;

    assign wait_done = wait_cnt == '0;

    // byte address split
    assign lane = req.addr[0];
    assign col  = req.addr[8:1];
    assign bank = req.addr[10:9];
    assign row  = req.addr[15:11];

    assign ref_take = state == sdram_pkg::st_idle && ref_pending;

    // refresh scheduler
    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt     <= '0;
            ref_pending <= 1'b0;
        end else begin
            if (ref_take)
                ref_pending <= 1'b0;
            if (ref_cnt == ref_w'(refresh_interval - 1)) begin
                ref_cnt     <= '0;
                ref_pending <= 1'b1;   // served at next idle
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= sdram_pkg::st_wait_power;
            wait_cnt    <= cnt_w'(init_cycles - 1);
            second_ref  <= 1'b0;
            ready       <= 1'b0;
            ack         <= 1'b0;
            pins.cmd    <= sdram_pkg::cmd_nop;
            pins.dqm    <= '0;
            pins.dq_oe  <= 1'b0;
        end else begin
            pins.cmd   <= sdram_pkg::cmd_nop;   // single-cycle commands
            pins.dqm   <= '0;
            pins.dq_oe <= 1'b0;
            ack        <= 1'b0;
            if (!wait_done)
                wait_cnt <= wait_cnt - 1'b1;

            case (state)
                sdram_pkg::st_wait_power: begin
                    if (wait_done) begin
                        pins.cmd <= sdram_pkg::cmd_precharge;
                        pins.a   <= 13'h0400;   // a10 all banks
                        wait_cnt <= cnt_w'(sdram_pkg::trp - 1);
                        state    <= sdram_pkg::st_precharge_all;
                    end
                end

                sdram_pkg::st_precharge_all: begin
                    if (wait_done) begin
                        pins.cmd   <= sdram_pkg::cmd_refresh;
                        wait_cnt   <= cnt_w'(sdram_pkg::trfc - 1);
                        second_ref <= 1'b0;
                        state      <= sdram_pkg::st_init_refresh;
                    end
                end

                sdram_pkg::st_init_refresh: begin
                    if (wait_done && !second_ref) begin
                        pins.cmd   <= sdram_pkg::cmd_refresh;   // second one
                        wait_cnt   <= cnt_w'(sdram_pkg::trfc - 1);
                        second_ref <= 1'b1;
                    end else if (wait_done) begin
                        pins.cmd <= sdram_pkg::cmd_load_mode;
                        pins.ba  <= 2'b00;
                        pins.a   <= sdram_pkg::mode_word;
                        wait_cnt <= cnt_w'(sdram_pkg::tmrd - 1);
                        state    <= sdram_pkg::st_load_mode;
                    end
                end

                sdram_pkg::st_load_mode: begin
                    if (wait_done) begin
                        ready <= 1'b1;   // init complete
                        state <= sdram_pkg::st_idle;
                    end
                end

                sdram_pkg::st_idle: begin
                    if (ref_pending) begin   // refresh beats requests
                        pins.cmd <= sdram_pkg::cmd_refresh;
                        wait_cnt <= cnt_w'(sdram_pkg::trfc - 1);
                        state    <= sdram_pkg::st_refresh;
                    end else if (ready && (rd || wr)) begin
                        pins.cmd <= sdram_pkg::cmd_active;
                        pins.ba  <= bank;
                        pins.a   <= {8'b0, row};   // upper row bits zero
                        wait_cnt <= cnt_w'(trcd - 1);
                        state    <= sdram_pkg::st_activate;
                    end
                end

                sdram_pkg::st_refresh: begin
                    if (wait_done)
                        state <= sdram_pkg::st_idle;
                end

                sdram_pkg::st_activate: begin
                    if (wait_done) begin
                        pins.ba <= bank;
                        pins.a  <= {2'b00, 1'b1, 2'b00, col};   // a10 auto precharge
                        if (wr) begin
                            pins.cmd    <= sdram_pkg::cmd_write;
                            pins.dq_out <= {req.wdata, req.wdata};   // byte on both halves
                            pins.dq_oe  <= 1'b1;
                            pins.dqm    <= lane ? 2'b01 : 2'b10;   // mask other lane
                            state       <= sdram_pkg::st_access;
                        end else begin
                            pins.cmd <= sdram_pkg::cmd_read;
                            // device sees READ one edge later, data CL edges after that
                            wait_cnt <= cnt_w'(sdram_pkg::mode_cas_latency);
                            state    <= sdram_pkg::st_cas_wait;
                        end
                    end
                end

                sdram_pkg::st_access: begin
                    ack      <= 1'b1;   // write taken
                    wait_cnt <= cnt_w'(sdram_pkg::trp - 1);
                    state    <= sdram_pkg::st_done;
                end

                sdram_pkg::st_cas_wait: begin
                    if (wait_done) begin
                        rdata    <= lane ? dq_in[15:8] : dq_in[7:0];
                        ack      <= 1'b1;
                        wait_cnt <= cnt_w'(sdram_pkg::trp - 1);
                        state    <= sdram_pkg::st_done;
                    end
                end

                sdram_pkg::st_done: begin
                    if (wait_done)
                        state <= sdram_pkg::st_idle;   // bank precharged
                end

                default: state <= sdram_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- source/sdram_pkg.sv
package sdram_pkg;

    // command encoding {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_load_mode = 4'b0000,
        cmd_refresh   = 4'b0001,   // auto refresh
        cmd_precharge = 4'b0010,
        cmd_active    = 4'b0011,   // open row
        cmd_write     = 4'b0100,
        cmd_read      = 4'b0101,
        cmd_nop       = 4'b0111,
        cmd_deselect  = 4'b1111    // chip select high
    } sdram_cmd_t;

    // controller FSM
    typedef enum logic [3:0] {
        st_wait_power,     // power-up delay
        st_precharge_all,
        st_init_refresh,   // two refreshes during init
        st_load_mode,
        st_idle,
        st_refresh,        // periodic refresh
        st_activate,       // row open, waiting trcd
        st_access,         // write ack cycle
        st_cas_wait,       // read data latency
        st_done            // auto precharge recovery
    } ctrl_state_t;

    // everything driven towards the device
    typedef struct packed {
        sdram_cmd_t  cmd;
        logic [1:0]  ba;       // bank
        logic [12:0] a;        // row / column / mode
        logic [1:0]  dqm;      // byte masks, 1 = masked
        logic [15:0] dq_out;
        logic        dq_oe;    // drive dq
    } sdram_pins_t;

    localparam int mode_cas_latency = 2;

    // BL1, sequential, single write burst
    localparam logic [12:0] mode_word = {3'b000, 1'b1, 2'b00, 3'(mode_cas_latency),
                                         1'b0, 3'b000};

    localparam int trp  = 2;   // precharge to next command
    localparam int trfc = 7;   // refresh cycle
    localparam int tmrd = 2;   // mode load to next command

endpackage

//--- source/spi_pkg.sv
package spi_pkg;

    // command byte opening each transaction
    typedef enum logic [7:0] {
        op_write = 8'h00,   // host to sdram
        op_read  = 8'h01    // sdram to host
    } spi_op_t;

    // byte position inside one transaction
    typedef enum logic [1:0] {
        ph_cmd,             // opcode byte
        ph_addr_hi,         // address bits 15:8
        ph_addr_lo,         // address bits 7:0
        ph_data             // payload bytes, address auto increments
    } spi_phase_t;

    // byte request from slave to controller
    typedef struct packed {
        logic [15:0] addr;  // byte address
        logic [7:0]  wdata; // write byte, ignored on reads
    } mem_req_t;

endpackage

//--- source/spirw_sdram_top.sv
`timescale 1ns/1ps

module spirw_sdram_top #(
    parameter int init_cycles      = 20000,
    parameter int refresh_interval = 750,
    parameter int trcd             = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  csn,
    input  logic                  sclk,
    input  logic                  mosi,
    output logic                  miso,
    output sdram_pkg::sdram_cmd_t sdram_cmd,
    output logic [1:0]            sdram_ba,
    output logic [12:0]           sdram_a,
    output logic [1:0]            sdram_dqm,
    output logic [15:0]           sdram_dq_out,
    output logic                  sdram_dq_oe,   // external tristate enable
    input  logic [15:0]           sdram_dq_in,
    output logic                  ready
);
    logic                   ram_rd;
    logic                   ram_wr;
    logic                   ram_ack;
    logic [7:0]             ram_rdata;
    spi_pkg::mem_req_t      ram_req;
    sdram_pkg::sdram_pins_t pins;

    spirw_slave slave0 (
        .clk   (clk),
        .rst   (rst),
        .csn   (csn),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso),
        .rd    (ram_rd),
        .wr    (ram_wr),
        .req   (ram_req),
        .ack   (ram_ack),
        .rdata (ram_rdata)
    );

    sdram_ctrl #(
        .init_cycles      (init_cycles),
        .refresh_interval (refresh_interval),
        .trcd             (trcd)
    ) ctrl0 (
        .clk   (clk),
        .rst   (rst),
        .rd    (ram_rd),
        .wr    (ram_wr),
        .req   (ram_req),
        .ack   (ram_ack),
        .rdata (ram_rdata),
        .ready (ready),
        .pins  (pins),
        .dq_in (sdram_dq_in)
    );

    // pin bundle out to device ports
    assign sdram_cmd    = pins.cmd;
    assign sdram_ba     = pins.ba;
    assign sdram_a      = pins.a;
    assign sdram_dqm    = pins.dqm;
    assign sdram_dq_out = pins.dq_out;
    assign sdram_dq_oe  = pins.dq_oe;

endmodule

//--- source/spirw_slave.sv
`timescale 1ns/1ps

module spirw_slave (
    input  logic              clk,
    input  logic              rst,
    input  logic              csn,
    input  logic              sclk,
    input  logic              mosi,
    output logic              miso,
    output logic              rd,
    output logic              wr,
    output spi_pkg::mem_req_t req,
    input  logic              ack,
    input  logic [7:0]        rdata
);
    logic [2:0]          sclk_sync;   // 2 sync flops + edge history
    logic [1:0]          mosi_sync;
    logic [1:0]          csn_sync;
    logic                sclk_rise;
    logic                sclk_fall;
    logic                cs_idle;     // synced csn high
    logic [7:0]          shift_in;
    logic [7:0]          rx_byte;     // byte incl. current bit
    logic [2:0]          bit_cnt;
    logic                byte_done;
    logic                data_phase;
    logic                issue_rd;
    logic                issue_wr;
    logic                tx_load;
    logic                rbuf_full;   // read byte waiting for byte boundary
    logic [7:0]          rbuf;
    logic [7:0]          tx_shift;
    logic [15:0]         addr;        // running byte address
    spi_pkg::spi_phase_t phase;
    spi_pkg::spi_op_t    op;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            csn_sync  <= '1;   // deselected
        end else begin
            sclk_sync <= {sclk_sync[1:0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            csn_sync  <= {csn_sync[0], csn};
        end
    end

    assign sclk_rise  = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall  = ~sclk_sync[1] & sclk_sync[2];
    assign cs_idle    = csn_sync[1];
    assign rx_byte    = {shift_in[6:0], mosi_sync[1]};   // msb first
    assign byte_done  = sclk_rise && !cs_idle && bit_cnt == 3'd7;
    assign data_phase = phase == spi_pkg::ph_data;

    // first read right after address, then one per data byte start
    assign issue_rd = op == spi_pkg::op_read &&
                      ((byte_done && phase == spi_pkg::ph_addr_lo) ||
                       (sclk_rise && !cs_idle && data_phase && bit_cnt == 3'd0));
    assign issue_wr = op == spi_pkg::op_write && byte_done && data_phase;

    // returned byte enters tx shifter only between bytes with sclk low
    assign tx_load = rbuf_full && !cs_idle && bit_cnt == 3'd0 && !sclk_sync[1];

    always_ff @(posedge clk) begin
        if (rst || cs_idle) begin
            bit_cnt <= '0;
            phase   <= spi_pkg::ph_cmd;   // restart on csn high
        end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7 && !data_phase)
                phase <= spi_pkg::spi_phase_t'(phase + 1'b1);   // stays in data phase
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise)
            shift_in <= rx_byte;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op <= spi_pkg::op_write;
            rd <= 1'b0;
            wr <= 1'b0;
        end else begin
            if (ack) begin   // handshake done
                rd <= 1'b0;
                wr <= 1'b0;
            end
            if (byte_done && phase == spi_pkg::ph_cmd)
                op <= spi_pkg::spi_op_t'(rx_byte);
            if (issue_rd)
                rd <= 1'b1;
            if (issue_wr)
                wr <= 1'b1;
        end
    end

    // address and request payload
    always_ff @(posedge clk) begin
        if (byte_done) begin
            case (phase)
                spi_pkg::ph_addr_hi: addr[15:8] <= rx_byte;
                spi_pkg::ph_addr_lo: addr[7:0]  <= rx_byte;
                spi_pkg::ph_data:    addr       <= addr + 16'd1;   // next byte
                default:             addr       <= addr;
            endcase
        end
        if (issue_rd)
            req.addr <= data_phase ? addr + 16'd1 : {addr[15:8], rx_byte};   // one byte ahead
        if (issue_wr) begin
            req.addr  <= addr;
            req.wdata <= rx_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || cs_idle)
            rbuf_full <= 1'b0;
        else if (ack && rd)
            rbuf_full <= 1'b1;
        else if (tx_load)
            rbuf_full <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ack && rd)
            rbuf <= rdata;   // read data valid with ack
        if (tx_load)
            tx_shift <= rbuf;
        else if (sclk_fall && bit_cnt != 3'd0)
            tx_shift <= {tx_shift[6:0], 1'b0};   // mode 0, change on falling edge
    end

    assign miso = tx_shift[7] & ~cs_idle;

endmodule
